// File: compile.f
+incdir+hdl
hdl/spi_pkg.sv
hdl/spi_baud.sv
hdl/spi_shifter.sv
hdl/spi_regs.sv
hdl/spi_periph.sv
test/spi_checker.sv
test/spi_periph_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the SPI peripheral testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module spi_periph_tb -f compile.f \
    && ./obj_dir/Vspi_periph_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "Done: errors found" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

// File: test/spi_periph_tb.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_periph_tb;

    typedef struct packed {
        logic [3:0]  cr;    // lsb_first, cpol, cpha, enable
        logic [15:0] brr;
        logic [3:0]  count;
        logic        pause;
    } row_t;

    localparam int NROWS = 8;
    localparam row_t ROWS [NROWS] = '{
        '{4'b0001, 16'd1, 4'd3, 1'b0},
        '{4'b0011, 16'd2, 4'd2, 1'b0},
        '{4'b0101, 16'd1, 4'd2, 1'b0},
        '{4'b0111, 16'd3, 4'd2, 1'b1},
        '{4'b1001, 16'd1, 4'd2, 1'b0},
        '{4'b1011, 16'd2, 4'd2, 1'b1},
        '{4'b1101, 16'd1, 4'd2, 1'b0},
        '{4'b1111, 16'd4, 4'd3, 1'b1}
    };
    localparam logic [31:0] TBE_M  = 32'h1 << `SPI_SR_TBE;
    localparam logic [31:0] RBF_M  = 32'h1 << `SPI_SR_RBF;
    localparam logic [31:0] BUSY_M = 32'h1 << `SPI_SR_BUSY;

    logic        seq = 1'b0;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;
    logic        pause_req;
    logic        pause_ack;
    logic        sclk;
    logic        mosi;
    logic        ss_n;
    logic        exp_valid;
    logic        exp_read;
    logic [31:0] exp_data;
    logic        exp_err;
    logic        irq_chk;
    logic        irq_exp;
    int          value_errors;
    int          rule_errors;
    int          stall_errors = 0;
    logic [15:0] lfsr = 16'd54080;

    always #20 seq = ~seq;

    spi_periph spi_periph_i (
        .seq(seq), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .irq(irq), .pause_req(pause_req), .pause_ack(pause_ack),
        .sclk(sclk), .mosi(mosi), .miso(mosi), .ss_n(ss_n) // Loopback
    );

    spi_checker spi_checker_i (
        .seq(seq), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .sclk(sclk), .ss_n(ss_n), .irq(irq), .pause_ack(pause_ack),
        .exp_valid(exp_valid), .exp_read(exp_read), .exp_data(exp_data), .exp_err(exp_err),
        .irq_chk(irq_chk), .irq_exp(irq_exp),
        .value_errors(value_errors), .rule_errors(rule_errors)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic next_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0]; // One step per bit
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // One setup and one access cycle, then an idle cycle
    task automatic apb(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                       input logic [3:0] strb, input logic check, input logic [31:0] exp,
                       input logic err, output logic [31:0] rdata);
        @(posedge seq);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wr ? data : '0;
        pstrb   <= wr ? strb : '0;
        @(posedge seq);
        penable   <= 1'b1;
        exp_valid <= check;
        exp_read  <= !wr && !err;
        exp_data  <= exp;
        exp_err   <= err;
        @(negedge seq);
        rdata = prdata;
        @(posedge seq);
        psel      <= 1'b0;
        penable   <= 1'b0;
        exp_valid <= 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic err);
        logic [31:0] rdata;
        apb(1'b1, addr, data, strb, 1'b1, '0, err, rdata);
    endtask

    task automatic read_check(input logic [31:0] addr, input logic [31:0] exp,
                              input logic err);
        logic [31:0] rdata;
        apb(1'b0, addr, '0, '0, 1'b1, exp, err, rdata);
    endtask

    task automatic poll_sr(input logic [31:0] mask, input logic [31:0] want,
                           input string what);
        logic [31:0] sr;
        int          tries;
        apb(1'b0, `SPI_REG_SR, '0, '0, 1'b0, '0, 1'b0, sr);
        tries = 1;
        while (((sr & mask) != want) && tries < 400) begin
            apb(1'b0, `SPI_REG_SR, '0, '0, 1'b0, '0, 1'b0, sr);
            tries++;
        end
        if ((sr & mask) != want) begin
            $display("Gave up waiting for %s after %0d status reads", what, tries);
            stall_errors++;
        end
    endtask

    task automatic expect_irq(input logic v);
        @(posedge seq);
        irq_chk <= 1'b1;
        irq_exp <= v;
        @(posedge seq);
        irq_chk <= 1'b0;
    endtask

    task automatic receive_byte(input logic [7:0] b);
        poll_sr(RBF_M, RBF_M, "RBF");
        read_check(`SPI_REG_DR, {24'h0, b}, 1'b0);
        poll_sr(BUSY_M, '0, "busy to clear");
        read_check(`SPI_REG_SR, TBE_M, 1'b0); // RBF gone after the DR read
    endtask

    task automatic send_byte(input logic [7:0] b);
        poll_sr(TBE_M, TBE_M, "TBE");
        write_reg(`SPI_REG_DR, {24'h0, b}, 4'hF, 1'b0);
        receive_byte(b);
    endtask

    task automatic paused_pair(input logic [7:0] b1, input logic [7:0] b2);
        int waited;
        poll_sr(TBE_M, TBE_M, "TBE");
        write_reg(`SPI_REG_DR, {24'h0, b1}, 4'hF, 1'b0);
        poll_sr(BUSY_M, BUSY_M, "frame start");
        @(posedge seq);
        pause_req <= 1'b1; // Mid frame
        waited = 0;
        @(negedge seq);
        while (!pause_ack && waited < 2000) begin
            @(negedge seq);
            waited++;
        end
        if (!pause_ack) begin
            $display("pause_ack did not rise after pause_req");
            stall_errors++;
        end
        read_check(`SPI_REG_SR, TBE_M | RBF_M, 1'b0); // Not busy once acked
        read_check(`SPI_REG_DR, {24'h0, b1}, 1'b0);
        write_reg(`SPI_REG_DR, {24'h0, b2}, 4'hF, 1'b0);
        read_check(`SPI_REG_SR, '0, 1'b0);
        repeat (40) @(posedge seq);
        read_check(`SPI_REG_SR, '0, 1'b0);    // Still pending
        @(posedge seq);
        pause_req <= 1'b0;
        receive_byte(b2);
    endtask

    initial begin : watchdog
        realtime limit;
        limit = 0;
        for (int r = 0; r < NROWS; r++)
            limit += real'(ROWS[r].count) * 18.0 * real'(ROWS[r].brr + 1) * 40.0;
        limit = limit * 4.0 + 50000.0;
        #(limit);
        $display("Timeout: run did not finish within %0.0f ns", limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        logic [7:0] b;
        logic [7:0] b2;
        int         first;
        int         total;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pstrb     = '0;
        pause_req = 1'b0;
        exp_valid = 1'b0;
        exp_read  = 1'b0;
        exp_data  = '0;
        exp_err   = 1'b0;
        irq_chk   = 1'b0;
        irq_exp   = 1'b0;
        repeat (8) @(posedge seq);
        rst_n <= 1'b1;

        // Reset values and plain register access
        expect_irq(1'b0);
        read_check(`SPI_REG_CR, '0, 1'b0);
        read_check(`SPI_REG_BRR, `SPI_BAUD_RESET, 1'b0);
        read_check(`SPI_REG_IER, '0, 1'b0);
        read_check(`SPI_REG_SR, TBE_M, 1'b0);
        write_reg(`SPI_REG_BRR, 32'h0000_1234, 4'hF, 1'b0);
        read_check(`SPI_REG_BRR, 32'h0000_1234, 1'b0);
        write_reg(`SPI_REG_BRR, 32'hFFFF_ABCD, 4'b0010, 1'b0);
        read_check(`SPI_REG_BRR, 32'h0000_AB34, 1'b0);
        write_reg(`SPI_REG_IER, 32'hA5A5_5A5A, 4'b0101, 1'b0);
        read_check(`SPI_REG_IER, 32'h00A5_005A, 1'b0);
        write_reg(`SPI_REG_IER, '0, 4'hF, 1'b0);
        write_reg(`SPI_REG_CR, 32'h0000_00F0, 4'b0001, 1'b0);
        read_check(`SPI_REG_CR, 32'h0000_00F0, 1'b0);
        write_reg(`SPI_REG_CR, '0, 4'hF, 1'b0);
        write_reg(`SPI_REG_SR, 32'hFFFF_FFFF, 4'hF, 1'b0); // Ignored
        read_check(`SPI_REG_SR, TBE_M, 1'b0);
        read_check(32'h14, '0, 1'b1);
        write_reg(32'h20, 32'h1, 4'hF, 1'b1);

        // DR while disabled
        read_check(`SPI_REG_DR, '0, 1'b1);
        write_reg(`SPI_REG_DR, 32'h5A, 4'hF, 1'b1);
        read_check(`SPI_REG_SR, TBE_M, 1'b0);
        write_reg(`SPI_REG_CR, 32'h1, 4'hF, 1'b0);
        write_reg(`SPI_REG_BRR, 32'h1, 4'hF, 1'b0);
        read_check(`SPI_REG_DR, '0, 1'b0);

        // Interrupt level
        write_reg(`SPI_REG_IER, 32'hFFFF_FFFF, 4'hF, 1'b0);
        expect_irq(1'b1); // TBE set
        write_reg(`SPI_REG_IER, RBF_M, 4'hF, 1'b0);
        expect_irq(1'b0);
        next_byte(b);
        write_reg(`SPI_REG_DR, {24'h0, b}, 4'hF, 1'b0);
        poll_sr(RBF_M, RBF_M, "RBF");
        expect_irq(1'b1);
        read_check(`SPI_REG_DR, {24'h0, b}, 1'b0);
        expect_irq(1'b0);
        write_reg(`SPI_REG_IER, 32'hFFFF_FFFF, 4'hF, 1'b0);

        for (int r = 0; r < NROWS; r++) begin
            poll_sr(BUSY_M, '0, "idle before mode change");
            write_reg(`SPI_REG_CR, 32'(ROWS[r].cr), 4'hF, 1'b0);
            read_check(`SPI_REG_CR, 32'(ROWS[r].cr), 1'b0);
            write_reg(`SPI_REG_BRR, 32'(ROWS[r].brr), 4'hF, 1'b0);
            read_check(`SPI_REG_BRR, 32'(ROWS[r].brr), 1'b0);
            first = 0;
            if (ROWS[r].pause) begin
                next_byte(b);
                next_byte(b2);
                paused_pair(b, b2);
                first = 2;
            end
            for (int n = first; n < ROWS[r].count; n++) begin
                next_byte(b);
                send_byte(b);
            end
        end

        repeat (4) @(posedge seq);
        total = value_errors + rule_errors + stall_errors;
        $display("Error count: %0d value, %0d rule, %0d stall",
                 value_errors, rule_errors, stall_errors);
        if (total == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: test/spi_checker.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_checker import spi_pkg::*; (
    input  logic        seq,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    input  logic [3:0]  pstrb,
    input  logic [31:0] prdata,
    input  logic        pready,
    input  logic        pslverr,
    input  logic        sclk,
    input  logic        ss_n,
    input  logic        irq,
    input  logic        pause_ack,
    input  logic        exp_valid, // Compare this access cycle
    input  logic        exp_read,
    input  logic [31:0] exp_data,
    input  logic        exp_err,
    input  logic        irq_chk,
    input  logic        irq_exp,
    output int          value_errors,
    output int          rule_errors
);

    reg_sel_e sel;
    logic     access;
    logic     cpol_q;  // CR.cpol as seen on the bus
    int       n_value = 0;
    int       n_rule = 0;

    always_comb begin
        case (paddr)
            `SPI_REG_DR:  sel = REG_DR;
            `SPI_REG_CR:  sel = REG_CR;
            `SPI_REG_SR:  sel = REG_SR;
            `SPI_REG_BRR: sel = REG_BRR;
            `SPI_REG_IER: sel = REG_IER;
            default:      sel = REG_NONE;
        endcase
    end

    assign access       = psel && penable;
    assign value_errors = n_value;
    assign rule_errors  = n_rule;

    // Everything sampled mid cycle
    always @(negedge seq) begin
        if (!rst_n) begin
            cpol_q = 1'b0;
        end else begin
            if (ss_n && sclk !== cpol_q) begin
                $display("** Error sclk expected 0x%0h got 0x%0h with ss_n high", cpol_q, sclk);
                n_value++;
            end
            if (pause_ack && !ss_n) begin
                $display("pause_ack was high while a frame was running at %0t", $time);
                n_rule++;
            end
            if (access && pready !== 1'b1) begin
                $display("pready was not high in an access cycle at %0t", $time);
                n_rule++;
            end
            if (access && exp_valid && pslverr !== exp_err) begin
                $display("** Error pslverr expected 0x%0h got 0x%0h (%s)",
                         exp_err, pslverr, sel.name());
                n_value++;
            end
            if (access && exp_valid && exp_read && prdata !== exp_data) begin
                $display("** Error prdata expected 0x%0h got 0x%0h (%s)",
                         exp_data, prdata, sel.name());
                n_value++;
            end
            if (irq_chk && irq !== irq_exp) begin
                $display("** Error irq expected 0x%0h got 0x%0h", irq_exp, irq);
                n_value++;
            end
            // Model follows CR after the checks since the DUT takes it at the next edge
            if (access && pwrite && sel == REG_CR && pstrb[0])
                cpol_q = pwdata[`SPI_CR_CPOL];
        end
    end

endmodule

// File: hdl/spi_periph.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_periph import spi_pkg::*; (
    input  logic                         seq,
    input  logic                         rst_n,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [`SPI_ADDR_WIDTH-1:0]   paddr,
    input  logic [`SPI_DATA_WIDTH-1:0]   pwdata,
    input  logic [`SPI_DATA_WIDTH/8-1:0] pstrb,
    output logic [`SPI_DATA_WIDTH-1:0]   prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         irq,
    input  logic                         pause_req,
    output logic                         pause_ack,
    output logic                         sclk,
    output logic                         mosi,
    input  logic                         miso,
    output logic                         ss_n
);

    logic                       start;
    logic [`SPI_FRAME_BITS-1:0] tx_byte;
    logic                       cpol;
    logic                       cpha;
    logic                       lsb_first;
    logic [`SPI_BAUD_WIDTH-1:0] divisor;
    shift_state_e               state;
    logic                       done;
    logic [`SPI_FRAME_BITS-1:0] rx_byte;
    logic                       run;
    logic                       tick;

    spi_regs spi_regs_i (
        .seq       (seq),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .irq       (irq),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .start     (start),
        .tx_byte   (tx_byte),
        .cpol      (cpol),
        .cpha      (cpha),
        .lsb_first (lsb_first),
        .divisor   (divisor),
        .state     (state),
        .done      (done),
        .rx_byte   (rx_byte)
    );

    spi_baud spi_baud_i (
        .seq     (seq),
        .rst_n   (rst_n),
        .run     (run),
        .divisor (divisor),
        .tick    (tick)
    );

    spi_shifter spi_shifter_i (
        .seq       (seq),
        .rst_n     (rst_n),
        .start     (start),
        .tx_byte   (tx_byte),
        .cpol      (cpol),
        .cpha      (cpha),
        .lsb_first (lsb_first),
        .tick      (tick),
        .run       (run),
        .state     (state),
        .done      (done),
        .rx_byte   (rx_byte),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso),
        .ss_n      (ss_n)
    );

endmodule

// File: hdl/spi_regs.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_regs import spi_pkg::*; (
    input  logic                         seq,
    input  logic                         rst_n,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [`SPI_ADDR_WIDTH-1:0]   paddr,
    input  logic [`SPI_DATA_WIDTH-1:0]   pwdata,
    input  logic [`SPI_DATA_WIDTH/8-1:0] pstrb,
    output logic [`SPI_DATA_WIDTH-1:0]   prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         irq,
    input  logic                         pause_req,
    output logic                         pause_ack,
    output logic                         start,
    output logic [`SPI_FRAME_BITS-1:0]   tx_byte,
    output logic                         cpol,
    output logic                         cpha,
    output logic                         lsb_first,
    output logic [`SPI_BAUD_WIDTH-1:0]   divisor,
    input  shift_state_e                 state,
    input  logic                         done,
    input  logic [`SPI_FRAME_BITS-1:0]   rx_byte
);

    reg_sel_e                   sel;
    logic                       setup;
    logic                       access;
    logic                       bad;
    logic                       wr_ok;
    logic                       rd_ok;
    logic [`SPI_DATA_WIDTH-1:0] cr;
    logic [`SPI_DATA_WIDTH-1:0] ier;
    logic [`SPI_DATA_WIDTH-1:0] sr;
    logic [`SPI_DATA_WIDTH-1:0] rdata;
    logic [`SPI_BAUD_WIDTH-1:0] brr;
    logic [`SPI_FRAME_BITS-1:0] tx_buf;
    logic [`SPI_FRAME_BITS-1:0] rx_buf;
    logic                       tx_full;
    logic                       rx_full;
    logic                       enable;

    // Byte lane merge for strobed writes
    function automatic logic [`SPI_DATA_WIDTH-1:0] merge(
        input logic [`SPI_DATA_WIDTH-1:0]   old,
        input logic [`SPI_DATA_WIDTH-1:0]   wdata,
        input logic [`SPI_DATA_WIDTH/8-1:0] strb
    );
        logic [`SPI_DATA_WIDTH-1:0] res;
        res = old;
        for (int i = 0; i < `SPI_DATA_WIDTH/8; i++) begin
            if (strb[i])
                res[8*i +: 8] = wdata[8*i +: 8];
        end
        return res;
    endfunction

    always_comb begin
        case (paddr)
            `SPI_REG_DR:  sel = REG_DR;
            `SPI_REG_CR:  sel = REG_CR;
            `SPI_REG_SR:  sel = REG_SR;
            `SPI_REG_BRR: sel = REG_BRR;
            `SPI_REG_IER: sel = REG_IER;
            default:      sel = REG_NONE;
        endcase
    end

    assign setup  = psel && !penable;
    assign access = psel && penable;
    assign bad    = (sel == REG_NONE) || (sel == REG_DR && !enable);
    assign wr_ok  = access && pwrite && !pslverr; // Error flag was latched in setup
    assign rd_ok  = access && !pwrite && !pslverr;

    assign enable    = cr[`SPI_CR_ENABLE];
    assign cpha      = cr[`SPI_CR_CPHA];
    assign cpol      = cr[`SPI_CR_CPOL];
    assign lsb_first = cr[`SPI_CR_LSB];
    assign divisor   = brr;
    assign tx_byte   = tx_buf;
    assign pready    = 1'b1;

    always_comb begin
        sr                = '0;
        sr[`SPI_SR_TBE]   = !tx_full;
        sr[`SPI_SR_RBF]   = rx_full;
        sr[`SPI_SR_BUSY]  = (state != IDLE);
    end

    assign irq = |(sr & ier);

    // Hand the pending byte over only when nothing holds it back
    assign start = tx_full && (state == IDLE) && enable && !pause_req && !pause_ack;

    always_comb begin
        case (sel)
            REG_DR:  rdata = `SPI_DATA_WIDTH'(rx_buf);
            REG_CR:  rdata = cr;
            REG_SR:  rdata = sr;
            REG_BRR: rdata = `SPI_DATA_WIDTH'(brr);
            REG_IER: rdata = ier;
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            cr        <= '0;
            ier       <= '0;
            brr       <= `SPI_BAUD_RESET;
            pslverr   <= 1'b0;
            tx_full   <= 1'b0;
            rx_full   <= 1'b0;
            rx_buf    <= '0;
            pause_ack <= 1'b0;
        end else begin
            pslverr <= setup && bad;
            if (wr_ok) begin
                case (sel)
                    REG_CR:  cr <= merge(cr, pwdata, pstrb);
                    REG_IER: ier <= merge(ier, pwdata, pstrb);
                    REG_BRR: brr <= `SPI_BAUD_WIDTH'(merge(`SPI_DATA_WIDTH'(brr), pwdata, pstrb));
                    default: ; // SR is read only, DR handled below
                endcase
            end
            // A new write wins over the start that empties the buffer
            if (wr_ok && sel == REG_DR && pstrb[0])
                tx_full <= 1'b1;
            else if (start)
                tx_full <= 1'b0;
            if (done) begin
                rx_buf  <= rx_byte; // Overwrites an unread byte
                rx_full <= 1'b1;
            end else if (rd_ok && sel == REG_DR) begin
                rx_full <= 1'b0;
            end
            if (!pause_req)
                pause_ack <= 1'b0;
            else if (state == IDLE)
                pause_ack <= 1'b1;
        end
    end

    always_ff @(posedge seq) begin
        if (wr_ok && sel == REG_DR && pstrb[0])
            tx_buf <= pwdata[`SPI_FRAME_BITS-1:0];
        if (setup && !pwrite)
            prdata <= rdata; // Valid in the access cycle
    end

endmodule

// File: hdl/spi_shifter.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_shifter import spi_pkg::*; (
    input  logic                       seq,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic [`SPI_FRAME_BITS-1:0] tx_byte,
    input  logic                       cpol,
    input  logic                       cpha,
    input  logic                       lsb_first,
    input  logic                       tick,
    output logic                       run,
    output shift_state_e               state,
    output logic                       done,
    output logic [`SPI_FRAME_BITS-1:0] rx_byte,
    output logic                       sclk,
    output logic                       mosi,
    input  logic                       miso,
    output logic                       ss_n
);

    localparam int MSB   = `SPI_FRAME_BITS - 1;
    localparam int EDGES = 2 * `SPI_FRAME_BITS;
    localparam int EW    = $clog2(EDGES);

    logic [MSB:0]  tx_sr;
    logic [MSB:0]  rx_sr;
    logic [MSB:0]  load_byte;
    logic [EW-1:0] edge_cnt;
    logic          phase;   // sclk relative to the idle level
    logic          cpha_q;
    logic          lsb_q;
    logic          mosi_q;
    logic          leading;
    logic          trailing;
    logic          sample;
    logic          shift_out;
    logic          last_edge;

    function automatic logic [MSB:0] reverse(input logic [MSB:0] b);
        logic [MSB:0] r;
        for (int i = 0; i <= MSB; i++) begin
            r[i] = b[MSB-i];
        end
        return r;
    endfunction

    assign load_byte = lsb_first ? reverse(tx_byte) : tx_byte;

    always_comb begin
        leading   = (state == SHIFT) && tick && !edge_cnt[0];
        trailing  = (state == SHIFT) && tick && edge_cnt[0];
        sample    = cpha_q ? trailing : leading;
        shift_out = cpha_q ? leading : trailing;
        last_edge = trailing && (edge_cnt == EW'(EDGES - 1));
    end

    always_ff @(posedge seq) begin
        if (!rst_n) begin
            state    <= IDLE;
            edge_cnt <= '0;
            phase    <= 1'b0;
            cpha_q   <= 1'b0;
            lsb_q    <= 1'b0;
            mosi_q   <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= last_edge; // rx_sr already holds the last bit
            case (state)
                IDLE: if (start) begin
                    state  <= SELECT;
                    cpha_q <= cpha;
                    lsb_q  <= lsb_first;
                    mosi_q <= cpha ? 1'b0 : load_byte[MSB]; // cpha 0 presents bit early
                end
                SELECT: if (tick) begin
                    state    <= SHIFT;
                    edge_cnt <= '0;
                end
                SHIFT: if (tick) begin
                    phase    <= !phase;
                    edge_cnt <= edge_cnt + 1'b1;
                    if (last_edge)
                        state <= DESELECT;
                end
                DESELECT: if (tick) begin
                    state  <= IDLE;
                    mosi_q <= 1'b0;
                end
                default: state <= IDLE;
            endcase
            if (shift_out)
                mosi_q <= tx_sr[MSB];
        end
    end

    always_ff @(posedge seq) begin
        if (state == IDLE && start)
            tx_sr <= cpha ? load_byte : load_byte << 1;
        else if (shift_out)
            tx_sr <= tx_sr << 1;
        if (sample)
            rx_sr <= {rx_sr[MSB-1:0], miso};
    end

    assign run     = (state != IDLE);
    assign ss_n    = (state == IDLE);
    assign sclk    = cpol ^ phase;
    assign mosi    = mosi_q;
    assign rx_byte = lsb_q ? reverse(rx_sr) : rx_sr; // Back to register bit order

endmodule

// File: hdl/spi_baud.sv
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_baud (
    input  logic                       seq,
    input  logic                       rst_n,
    input  logic                       run,
    input  logic [`SPI_BAUD_WIDTH-1:0] divisor,
    output logic                       tick
);

    logic [`SPI_BAUD_WIDTH-1:0] cnt;

    // Counts divisor down to zero, so one tick per divisor+1 cycles
    always_ff @(posedge seq) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= divisor; // Restart so the first half bit is a full one
        end else if (cnt == '0) begin
            cnt <= divisor;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    assign tick = run && (cnt == '0);

endmodule

// File: hdl/spi_pkg.sv
package spi_pkg;

    // Target of an APB access after address decode
    typedef enum logic [2:0] {
        REG_DR,
        REG_CR,
        REG_SR,
        REG_BRR,
        REG_IER,
        REG_NONE  // Unmapped offset
    } reg_sel_e;

    // Frame sequencer of the shifter
    typedef enum logic [1:0] {
        IDLE,     // ss_n high, sclk at cpol
        SELECT,   // ss_n low for one half bit
        SHIFT,    // Two sclk edges per bit
        DESELECT  // Hold time before ss_n rises
    } shift_state_e;

endpackage

// File: hdl/spi_cfg.svh
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

`define SPI_ADDR_WIDTH 32
`define SPI_DATA_WIDTH 32
`define SPI_FRAME_BITS 8
`define SPI_BAUD_WIDTH 16
`define SPI_BAUD_RESET 16'd24 // Half bit of 25 cycles

// Register byte offsets
`define SPI_REG_DR  32'h00
`define SPI_REG_CR  32'h04
`define SPI_REG_SR  32'h08
`define SPI_REG_BRR 32'h0C
`define SPI_REG_IER 32'h10

// CR bit positions
`define SPI_CR_ENABLE 0
`define SPI_CR_CPHA   1
`define SPI_CR_CPOL   2
`define SPI_CR_LSB    3

// SR bit positions, IER uses the same ones
`define SPI_SR_TBE  0
`define SPI_SR_RBF  1
`define SPI_SR_BUSY 2

`endif
